// ==== io_pkg.sv ====
package io_pkg;

  // CPU bus word, used for both data and address
  typedef logic [15:0] word_t;

  // Port value, direction mask or LED byte
  typedef logic [7:0] pin_byte_t;

  // Hardware slot number of the four-slot CPU
  typedef logic [1:0] slot_t;

  // One kill request bit per slot, indexed by slot number
  typedef logic [3:0] kill_t;

  // Bit positions in the one-hot-per-device I/O address.
  // Bits 3, 11, 12 and 13 have no device behind them.
  typedef enum int unsigned {
    IO_PMOD       = 0,   // PMOD pins, read returns pads
    IO_PMOD_DIR   = 1,   // PMOD direction, 1 is output
    IO_LEDS       = 2,   // LED register
    IO_HDR1       = 4,   // HDR1 pins
    IO_HDR1_DIR   = 5,   // HDR1 direction
    IO_HDR2       = 6,   // HDR2 pins
    IO_HDR2_DIR   = 7,   // HDR2 direction
    IO_TASK1      = 8,   // Slot 1 token
    IO_TASK2      = 9,   // Slot 2 token
    IO_TASK3      = 10,  // Slot 3 token
    IO_TASK_FETCH = 14,  // Token of calling slot, write kills slots
    IO_SLOT_ID    = 15   // Number of calling slot
  } io_bit_e;

endpackage

// ==== io_capture.sv ====
`timescale 1ns/100ps

module io_capture (
  input  logic          clk,
  input  logic          resetq,
  input  logic          io_rd,     // One-cycle read strobe
  input  logic          io_wr,     // One-cycle write strobe
  input  io_pkg::word_t mem_addr,  // Bitmask address
  input  io_pkg::word_t dout,      // Write data from CPU
  input  io_pkg::slot_t io_slot,   // Slot doing the access
  output logic          rd_q,
  output logic          wr_q,
  output io_pkg::word_t wdata_q,
  output io_pkg::word_t sel_q,     // Zero when no access
  output io_pkg::slot_t slot_q
);

  import io_pkg::*;

  word_t sel_d;  // Address gated by the strobes

  // No strobe, no select bits, so idle addresses never actuate anything
  assign sel_d = (io_rd | io_wr) ? mem_addr : '0;

  // Control half of the stage
  always_ff @(posedge clk) begin
    if (!resetq) begin
      rd_q  <= 1'b0;
      wr_q  <= 1'b0;
      sel_q <= '0;
    end else begin
      rd_q  <= io_rd;
      wr_q  <= io_wr;
      sel_q <= sel_d;  // Lines up with delayed read data
    end
  end

  // Payload half, only meaningful alongside a strobe
  always_ff @(posedge clk) begin
    wdata_q <= dout;
    slot_q  <= io_slot;  // Slot ID is read back one cycle late too
  end

endmodule

// ==== gpio_bank.sv ====
`timescale 1ns/100ps

module gpio_bank (
  input  logic              clk,
  input  logic              resetq,
  input  logic              wr_q,      // Captured write strobe
  input  io_pkg::word_t     wdata_q,   // Only low byte is stored
  input  io_pkg::word_t     sel_q,     // Several regs may be hit at once
  input  io_pkg::pin_byte_t pmod_in,   // Pad inputs
  input  io_pkg::pin_byte_t hdr1_in,
  input  io_pkg::pin_byte_t hdr2_in,
  output io_pkg::pin_byte_t pmod_out,  // Output registers
  output io_pkg::pin_byte_t pmod_oe,   // Direction, 1 drives the pad
  output io_pkg::pin_byte_t hdr1_out,
  output io_pkg::pin_byte_t hdr1_oe,
  output io_pkg::pin_byte_t hdr2_out,
  output io_pkg::pin_byte_t hdr2_oe,
  output io_pkg::pin_byte_t led,
  output io_pkg::pin_byte_t pmod_rd,   // Pad read values to readback
  output io_pkg::pin_byte_t hdr1_rd,
  output io_pkg::pin_byte_t hdr2_rd
);

  import io_pkg::*;

  pin_byte_t wbyte;  // Byte written to every selected reg

  assign wbyte = wdata_q[7:0];

  // Ports read the pads, not the output registers
  assign pmod_rd = pmod_in;
  assign hdr1_rd = hdr1_in;
  assign hdr2_rd = hdr2_in;

  // Direction registers, everything comes up as input
  always_ff @(posedge clk) begin
    if (!resetq) begin
      pmod_oe <= '0;
      hdr1_oe <= '0;
      hdr2_oe <= '0;
    end else if (wr_q) begin
      if (sel_q[IO_PMOD_DIR])
        pmod_oe <= wbyte;
      if (sel_q[IO_HDR1_DIR])
        hdr1_oe <= wbyte;
      if (sel_q[IO_HDR2_DIR])
        hdr2_oe <= wbyte;
    end
  end

  // Output and LED registers
  always_ff @(posedge clk) begin
    if (!resetq) begin
      pmod_out <= '0;
      hdr1_out <= '0;
      hdr2_out <= '0;
      led      <= '0;
    end else if (wr_q) begin
      if (sel_q[IO_PMOD])
        pmod_out <= wbyte;
      if (sel_q[IO_HDR1])
        hdr1_out <= wbyte;
      if (sel_q[IO_HDR2])
        hdr2_out <= wbyte;
      if (sel_q[IO_LEDS])
        led <= wbyte;  // LEDs are always driven
    end
  end

endmodule

// ==== task_table.sv ====
`timescale 1ns/100ps

module task_table (
  input  logic          clk,
  input  logic          resetq,
  input  logic          rd_q,        // Captured read strobe
  input  logic          wr_q,        // Captured write strobe
  input  io_pkg::word_t wdata_q,
  input  io_pkg::word_t sel_q,
  input  io_pkg::slot_t slot_q,      // Slot that made the access
  output io_pkg::word_t xt1,         // Raw tokens for readback
  output io_pkg::word_t xt2,
  output io_pkg::word_t xt3,
  output io_pkg::word_t fetch_word,  // Token offered to slot_q
  output io_pkg::kill_t kill_rq      // Bit n kills slot n
);

  import io_pkg::*;

  word_t xt_q [1:3];  // Tokens of slots 1 to 3
  logic  fetch_rd;    // Read of the fetch address

  assign fetch_rd = rd_q & sel_q[IO_TASK_FETCH];

  // One token register per slot, slot 0 has none
  for (genvar s = 1; s <= 3; s++) begin : g_tok
    logic wr_hit;     // Write selects this token
    logic fetch_clr;  // Run-once token fetched by its own slot

    assign wr_hit    = wr_q & sel_q[int'(IO_TASK1) + s - 1];
    assign fetch_clr = fetch_rd & (slot_q == slot_t'(s)) & xt_q[s][0];

    always_ff @(posedge clk) begin
      if (!resetq)
        xt_q[s] <= '0;
      else if (wr_hit)
        xt_q[s] <= wdata_q;  // Write wins over a clear
      else if (fetch_clr)
        xt_q[s] <= '0;       // Odd token runs once
    end
  end

  assign xt1 = xt_q[1];
  assign xt2 = xt_q[2];
  assign xt3 = xt_q[3];

  // Valid tokens are even, bit 0 only flags run-once
  always_comb begin
    case (slot_q)
      2'd1:    fetch_word = {xt_q[1][15:1], 1'b0};
      2'd2:    fetch_word = {xt_q[2][15:1], 1'b0};
      2'd3:    fetch_word = {xt_q[3][15:1], 1'b0};
      default: fetch_word = '0;  // Slot 0 always starts from zero
    endcase
  end

  // Every write reloads the kill mask, so it clears on the next other write
  always_ff @(posedge clk) begin
    if (!resetq)
      kill_rq <= '0;
    else if (wr_q)
      kill_rq <= sel_q[IO_TASK_FETCH] ? wdata_q[3:0] : '0;
  end

endmodule

// ==== io_readback.sv ====
`timescale 1ns/100ps

module io_readback (
  input  io_pkg::word_t     sel_q,       // Captured select bits
  input  io_pkg::slot_t     slot_q,
  input  io_pkg::pin_byte_t pmod_in,     // Pad values, not out regs
  input  io_pkg::pin_byte_t pmod_oe,
  input  io_pkg::pin_byte_t led,
  input  io_pkg::pin_byte_t hdr1_in,
  input  io_pkg::pin_byte_t hdr1_oe,
  input  io_pkg::pin_byte_t hdr2_in,
  input  io_pkg::pin_byte_t hdr2_oe,
  input  io_pkg::word_t     xt1,
  input  io_pkg::word_t     xt2,
  input  io_pkg::word_t     xt3,
  input  io_pkg::word_t     fetch_word,
  output io_pkg::word_t     io_din       // CPU input word
);

  import io_pkg::*;

  // Source value if its select bit is set, else zero
  function automatic word_t pick(input logic en, input word_t val);
    return en ? val : '0;
  endfunction

  // Multi-bit selects OR their sources together
  assign io_din = pick(sel_q[IO_PMOD],       word_t'(pmod_in))
                | pick(sel_q[IO_PMOD_DIR],   word_t'(pmod_oe))
                | pick(sel_q[IO_LEDS],       word_t'(led))
                | pick(sel_q[IO_HDR1],       word_t'(hdr1_in))
                | pick(sel_q[IO_HDR1_DIR],   word_t'(hdr1_oe))
                | pick(sel_q[IO_HDR2],       word_t'(hdr2_in))
                | pick(sel_q[IO_HDR2_DIR],   word_t'(hdr2_oe))
                | pick(sel_q[IO_TASK1],      xt1)
                | pick(sel_q[IO_TASK2],      xt2)
                | pick(sel_q[IO_TASK3],      xt3)
                | pick(sel_q[IO_TASK_FETCH], fetch_word)
                | pick(sel_q[IO_SLOT_ID],    word_t'(slot_q));  // Slot ID

endmodule

// ==== io_top.sv ====
`timescale 1ns/100ps

module io_top (
  input  logic              clk,
  input  logic              resetq,
  input  logic              io_rd,
  input  logic              io_wr,
  input  io_pkg::word_t     mem_addr,
  input  io_pkg::word_t     dout,
  input  io_pkg::slot_t     io_slot,
  output io_pkg::word_t     io_din,    // Valid the cycle after the access
  input  io_pkg::pin_byte_t pmod_in,
  input  io_pkg::pin_byte_t hdr1_in,
  input  io_pkg::pin_byte_t hdr2_in,
  output io_pkg::pin_byte_t pmod_out,
  output io_pkg::pin_byte_t pmod_oe,
  output io_pkg::pin_byte_t hdr1_out,
  output io_pkg::pin_byte_t hdr1_oe,
  output io_pkg::pin_byte_t hdr2_out,
  output io_pkg::pin_byte_t hdr2_oe,
  output io_pkg::pin_byte_t led,
  output io_pkg::kill_t     kill_rq    // Slot kill requests
);

  import io_pkg::*;

  logic      rd_q;        // Captured access
  logic      wr_q;
  word_t     wdata_q;
  word_t     sel_q;
  slot_t     slot_q;
  pin_byte_t pmod_rd;     // Pad read values
  pin_byte_t hdr1_rd;
  pin_byte_t hdr2_rd;
  word_t     xt1;         // Tokens
  word_t     xt2;
  word_t     xt3;
  word_t     fetch_word;

  io_capture i_io_capture (
    .clk      (clk),      .resetq  (resetq),
    .io_rd    (io_rd),    .io_wr   (io_wr),
    .mem_addr (mem_addr), .dout    (dout),
    .io_slot  (io_slot),
    .rd_q     (rd_q),     .wr_q    (wr_q),
    .wdata_q  (wdata_q),  .sel_q   (sel_q),
    .slot_q   (slot_q)
  );

  gpio_bank i_gpio_bank (
    .clk      (clk),      .resetq   (resetq),
    .wr_q     (wr_q),     .wdata_q  (wdata_q),  .sel_q   (sel_q),
    .pmod_in  (pmod_in),  .hdr1_in  (hdr1_in),  .hdr2_in (hdr2_in),
    .pmod_out (pmod_out), .pmod_oe  (pmod_oe),
    .hdr1_out (hdr1_out), .hdr1_oe  (hdr1_oe),
    .hdr2_out (hdr2_out), .hdr2_oe  (hdr2_oe),
    .led      (led),
    .pmod_rd  (pmod_rd),  .hdr1_rd  (hdr1_rd),  .hdr2_rd (hdr2_rd)
  );

  task_table i_task_table (
    .clk     (clk),     .resetq     (resetq),
    .rd_q    (rd_q),    .wr_q       (wr_q),
    .wdata_q (wdata_q), .sel_q      (sel_q),  .slot_q (slot_q),
    .xt1     (xt1),     .xt2        (xt2),    .xt3    (xt3),
    .fetch_word (fetch_word),
    .kill_rq (kill_rq)
  );

  io_readback i_io_readback (
    .sel_q   (sel_q),   .slot_q  (slot_q),
    .pmod_in (pmod_rd), .pmod_oe (pmod_oe), .led (led),
    .hdr1_in (hdr1_rd), .hdr1_oe (hdr1_oe),
    .hdr2_in (hdr2_rd), .hdr2_oe (hdr2_oe),
    .xt1     (xt1),     .xt2     (xt2),     .xt3 (xt3),
    .fetch_word (fetch_word),
    .io_din  (io_din)
  );

endmodule

// ==== io_top_chk.sv ====
`timescale 1ns/100ps

module io_top_chk (
  input logic              clk,
  input logic              resetq,
  input logic              io_rd,
  input logic              io_wr,
  input io_pkg::word_t     sel_q,    // Internal capture select bits
  input io_pkg::pin_byte_t pmod_oe,
  input io_pkg::pin_byte_t hdr1_oe,
  input io_pkg::pin_byte_t hdr2_oe,
  input io_pkg::kill_t     kill_rq
);

  import io_pkg::*;

  int unsigned fail_cnt = 0;  // Failed assertion count

  // Idle edge leaves nothing selected
  a_idle_no_sel: assert property (@(posedge clk) !(io_rd || io_wr) |=> sel_q == '0)
    else begin
      fail_cnt++;
      $error("sel_q nonzero after an idle cycle");
    end

  // Pads stay inputs and no slot is killed in reset
  a_reset_safe: assert property (@(posedge clk)
    !resetq |=> (pmod_oe == '0 && hdr1_oe == '0 && hdr2_oe == '0 && kill_rq == '0))
    else begin
      fail_cnt++;
      $error("Outputs active during reset");
    end

  a_one_strobe: assert property (@(posedge clk) !(io_rd && io_wr))
    else begin
      fail_cnt++;
      $error("io_rd and io_wr high together");
    end

endmodule

bind io_top io_top_chk i_io_top_chk (
  .clk     (clk),
  .resetq  (resetq),
  .io_rd   (io_rd),
  .io_wr   (io_wr),
  .sel_q   (sel_q),
  .pmod_oe (pmod_oe),
  .hdr1_oe (hdr1_oe),
  .hdr2_oe (hdr2_oe),
  .kill_rq (kill_rq)
);

// ==== tb_io_top.sv ====
`timescale 1ns/100ps

module tb_io_top;

  import io_pkg::*;

  logic      clk;
  logic      resetq;
  logic      io_rd;
  logic      io_wr;
  word_t     mem_addr;
  word_t     dout;
  slot_t     io_slot;
  word_t     io_din;
  pin_byte_t pmod_in, hdr1_in, hdr2_in;
  pin_byte_t pmod_out, pmod_oe, hdr1_out, hdr1_oe, hdr2_out, hdr2_oe, led;
  kill_t     kill_rq;

  // Register model, updated one falling edge after the access
  pin_byte_t m_pmod_out, m_pmod_oe, m_hdr1_out, m_hdr1_oe, m_hdr2_out, m_hdr2_oe, m_led;
  word_t     m_xt [1:3];
  kill_t     m_kill;
  word_t     din_exp;   // Expected io_din of the pending read
  logic      din_pend;  // Read result due at this falling edge
  logic      regs_on;   // Register outputs are compared
  io_bit_e   reg_bits [7] = '{IO_PMOD, IO_PMOD_DIR, IO_LEDS, IO_HDR1, IO_HDR1_DIR,
                              IO_HDR2, IO_HDR2_DIR};

  io_top i_io_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    #50000;  // Guard against a stalled run
    abort_run("Timeout: the test sequence did not finish within 50 us");
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Stopping on first error");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string name);
    if (got !== exp)
      abort_run($sformatf("[ERROR] %0d ns %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_byte(input pin_byte_t got, input pin_byte_t exp, input string name);
    if (got !== exp)
      abort_run($sformatf("[ERROR] %0d ns %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_kill(input kill_t got, input kill_t exp, input string name);
    if (got !== exp)
      abort_run($sformatf("[ERROR] %0d ns %s got %h expected %h", $time, name, got, exp));
  endtask

  function automatic word_t bit_mask(input io_bit_e b);
    return word_t'(1) << b;
  endfunction

  // OR of every selected source, pins read from the pads
  function automatic word_t expected_din(input word_t addr, input slot_t slot);
    word_t v;
    v = '0;
    if (addr[IO_PMOD])     v |= {8'h00, pmod_in};
    if (addr[IO_PMOD_DIR]) v |= {8'h00, m_pmod_oe};
    if (addr[IO_LEDS])     v |= {8'h00, m_led};
    if (addr[IO_HDR1])     v |= {8'h00, hdr1_in};
    if (addr[IO_HDR1_DIR]) v |= {8'h00, m_hdr1_oe};
    if (addr[IO_HDR2])     v |= {8'h00, hdr2_in};
    if (addr[IO_HDR2_DIR]) v |= {8'h00, m_hdr2_oe};
    if (addr[IO_TASK1])    v |= m_xt[1];
    if (addr[IO_TASK2])    v |= m_xt[2];
    if (addr[IO_TASK3])    v |= m_xt[3];
    if (addr[IO_TASK_FETCH]) begin
      if (slot != 2'd0)
        v |= m_xt[slot] & 16'hFFFE;  // Run-once flag hidden
    end
    if (addr[IO_SLOT_ID])  v |= {14'h0000, slot};
    return v;
  endfunction

  task automatic update_model(input logic wr, input word_t addr, input word_t data,
                              input slot_t slot);
    if (wr) begin
      if (addr[IO_PMOD])     m_pmod_out <= data[7:0];
      if (addr[IO_PMOD_DIR]) m_pmod_oe  <= data[7:0];
      if (addr[IO_LEDS])     m_led      <= data[7:0];
      if (addr[IO_HDR1])     m_hdr1_out <= data[7:0];
      if (addr[IO_HDR1_DIR]) m_hdr1_oe  <= data[7:0];
      if (addr[IO_HDR2])     m_hdr2_out <= data[7:0];
      if (addr[IO_HDR2_DIR]) m_hdr2_oe  <= data[7:0];
      for (int s = 1; s <= 3; s++)
        if (addr[int'(IO_TASK1) + s - 1]) m_xt[s] <= data;
      m_kill <= addr[IO_TASK_FETCH] ? data[3:0] : '0;  // Any other write clears
    end else if (addr[IO_TASK_FETCH] && slot != 2'd0 && m_xt[slot][0]) begin
      m_xt[slot] <= '0;  // Odd token fetched once
    end
  endtask

  task automatic wait_falls(input int n);
    for (int i = 0; i < n; i++)
      @(negedge clk);
  endtask

  task automatic wait_known();
    int n;
    n = 0;
    while ($isunknown({io_din, pmod_oe, hdr1_oe, hdr2_oe, led, kill_rq}) && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (n == 10)
      abort_run("Timeout: DUT outputs still unknown 10 cycles after reset");
  endtask

  // One access cycle, then one idle cycle with a junk address
  task automatic access(input logic wr, input word_t addr, input word_t data,
                        input slot_t slot);
    pmod_in  = pin_byte_t'($urandom);
    hdr1_in  = pin_byte_t'($urandom);
    hdr2_in  = pin_byte_t'($urandom);
    io_rd    = !wr;
    io_wr    = wr;
    mem_addr = addr;
    dout     = data;
    io_slot  = slot;
    if (!wr) begin
      din_exp  <= expected_din(addr, slot);
      din_pend <= 1'b1;
    end
    wait_falls(1);
    io_rd    = 1'b0;
    io_wr    = 1'b0;
    mem_addr = word_t'($urandom);  // Must be ignored without a strobe
    dout     = word_t'($urandom);
    din_pend <= 1'b0;
    update_model(wr, addr, data, slot);
    wait_falls(1);
  endtask

  task automatic write_io(input word_t addr, input word_t data);
    access(1'b1, addr, data, 2'd0);
  endtask

  task automatic read_io(input word_t addr, input slot_t slot);
    access(1'b0, addr, 16'h0000, slot);
  endtask

  // Compares read data and register outputs at every falling edge
  always @(negedge clk) begin
    if (i_io_top.i_io_top_chk.fail_cnt != 0)
      abort_run("A concurrent assertion in io_top_chk failed");
    if (din_pend)
      check_word(io_din, din_exp, "io_din");
    if (regs_on) begin
      check_byte(pmod_out, m_pmod_out, "pmod_out");
      check_byte(pmod_oe,  m_pmod_oe,  "pmod_oe");
      check_byte(hdr1_out, m_hdr1_out, "hdr1_out");
      check_byte(hdr1_oe,  m_hdr1_oe,  "hdr1_oe");
      check_byte(hdr2_out, m_hdr2_out, "hdr2_out");
      check_byte(hdr2_oe,  m_hdr2_oe,  "hdr2_oe");
      check_byte(led,      m_led,      "led");
      check_kill(kill_rq,  m_kill,     "kill_rq");
    end
  end

  initial begin
    void'($urandom(27));
    resetq = 1'b0;
    io_rd = 1'b0;
    io_wr = 1'b0;
    mem_addr = '0;
    dout = '0;
    io_slot = '0;
    pmod_in = '0;
    hdr1_in = '0;
    hdr2_in = '0;
    {m_pmod_out, m_pmod_oe, m_hdr1_out, m_hdr1_oe, m_hdr2_out, m_hdr2_oe, m_led} = '0;
    m_xt = '{default: '0};
    m_kill = '0;
    din_exp = '0;
    din_pend = 1'b0;
    regs_on = 1'b0;
    for (int i = 0; i < 3; i++)
      @(posedge clk);  // Three rising edges in reset
    @(negedge clk);
    resetq = 1'b1;
    wait_known();
    regs_on <= 1'b1;
    read_io(bit_mask(IO_TASK1) | bit_mask(IO_TASK2) | bit_mask(IO_TASK3), 2'd0);
    read_io(bit_mask(IO_PMOD_DIR) | bit_mask(IO_HDR1_DIR) | bit_mask(IO_HDR2_DIR), 2'd0);
    foreach (reg_bits[i])
      write_io(bit_mask(reg_bits[i]), word_t'($urandom));
    foreach (reg_bits[i])
      read_io(bit_mask(reg_bits[i]), 2'd0);  // Port bits return pads
    write_io(bit_mask(IO_PMOD_DIR) | bit_mask(IO_HDR2) | bit_mask(IO_LEDS) |
             bit_mask(IO_HDR1_DIR), 16'h5AC3);
    read_io(bit_mask(IO_PMOD_DIR) | bit_mask(IO_LEDS) | bit_mask(IO_HDR1_DIR) |
            bit_mask(IO_HDR2), 2'd0);
    write_io(bit_mask(IO_TASK1), 16'h1234);  // Even, stays
    write_io(bit_mask(IO_TASK2), 16'h2469);  // Odd, runs once
    write_io(bit_mask(IO_TASK3), 16'h4AC7);
    read_io(bit_mask(IO_TASK1), 2'd0);
    read_io(bit_mask(IO_TASK2), 2'd0);
    read_io(bit_mask(IO_TASK3), 2'd0);
    for (int r = 0; r < 2; r++)
      for (int s = 0; s < 4; s++)
        read_io(bit_mask(IO_TASK_FETCH), slot_t'(s));
    read_io(bit_mask(IO_TASK1) | bit_mask(IO_TASK2) | bit_mask(IO_TASK3), 2'd0);
    write_io(bit_mask(IO_TASK_FETCH), 16'hFF0B);
    read_io(bit_mask(IO_SLOT_ID), 2'd1);  // Kill mask holds through reads
    read_io(bit_mask(IO_LEDS), 2'd0);
    write_io(bit_mask(IO_LEDS), 16'h0081);
    for (int s = 0; s < 4; s++)
      read_io(bit_mask(IO_SLOT_ID), slot_t'(s));
    wait_falls(2);
    if (i_io_top.i_io_top_chk.fail_cnt == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run("A concurrent assertion in io_top_chk failed");
    end
  end

endmodule

// ==== list.f ====
io_pkg.sv
io_capture.sv
gpio_bank.sv
task_table.sv
io_readback.sv
io_top.sv
io_top_chk.sv
tb_io_top.sv

// ==== Bender.yml ====
package:
  name: io_top

sources:
  - io_pkg.sv
  - io_capture.sv
  - gpio_bank.sv
  - task_table.sv
  - io_readback.sv
  - io_top.sv
  - target: test
    files:
      - io_top_chk.sv
      - tb_io_top.sv
